/* hdl/dmem_params.svh */
`ifndef DMEM_PARAMS_SVH
`define DMEM_PARAMS_SVH

// store buffer depth, power of two
`define DSTB_LINES 4

// one word per line
`define CACHE_LINES 8

// word addressed, MEM_WORDS == 2**ADDR_WIDTH
`define ADDR_WIDTH 8
`define MEM_WORDS 256

`define DATA_WIDTH 32

// backing memory read latency in cycles
`define MISS_CYCLES 4

`endif

/* hdl/mem_types_pkg.sv */
`include "dmem_params.svh"

package mem_types_pkg;

    typedef logic [`ADDR_WIDTH-1:0] mem_addr_t;

    typedef logic [`DATA_WIDTH-1:0] mem_word_t;

    // one store buffer slot
    typedef struct packed {
        logic      valid;
        mem_addr_t addr;
        mem_word_t data;
    } store_entry_t;

endpackage

/* hdl/mem_ops_pkg.sv */
package mem_ops_pkg;

    typedef enum logic [1:0] {
        OP_NOP   = 2'd0,
        OP_LOAD  = 2'd1,
        OP_STORE = 2'd2
    } mem_op_t;

    // miss handling
    typedef enum logic [1:0] {
        C_IDLE = 2'd0,
        C_FILL = 2'd1,
        C_RESP = 2'd2
    } cache_state_t;

endpackage

/* hdl/store_buffer.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module store_buffer (
    input  logic                      clk,
    input  logic                      rst,

    // store side
    input  logic                      i_store_en,
    input  mem_types_pkg::mem_addr_t  i_addr,
    input  mem_types_pkg::mem_word_t  i_wdata,

    // commit to cache
    input  logic                      i_commit_ack,
    output logic                      o_commit_valid,
    output mem_types_pkg::mem_addr_t  o_commit_addr,
    output mem_types_pkg::mem_word_t  o_commit_data,

    // status
    output logic                      o_full,
    output logic                      o_empty,

    // load bypass
    output logic                      o_bypass_hit,
    output mem_types_pkg::mem_word_t  o_bypass_data
);
    import mem_types_pkg::*;

    localparam int SEL_W = $clog2(`DSTB_LINES);

    store_entry_t       entries [`DSTB_LINES];
    logic [SEL_W-1:0]   oldest;
    logic [SEL_W-1:0]   newest;
    logic [SEL_W-1:0]   scan_idx;
    logic               store_wr;

    // only flagged while a store actually wants the slot
    assign o_full   = i_store_en && entries[newest].valid;
    assign store_wr = i_store_en && !entries[newest].valid;

    // entries are contiguous from oldest, so an empty oldest slot means empty ring
    assign o_empty = !entries[oldest].valid;

    assign o_commit_valid = entries[oldest].valid;
    assign o_commit_addr  = entries[oldest].addr;
    assign o_commit_data  = entries[oldest].data;

    // walk oldest to newest, last match is the youngest
    always_comb begin
        o_bypass_hit  = 1'b0;
        o_bypass_data = '0;
        scan_idx      = oldest;
        for (int i = 0; i < `DSTB_LINES; i++) begin
            scan_idx = oldest + SEL_W'(i); // wraps, depth is a power of two
            if (entries[scan_idx].valid && (entries[scan_idx].addr == i_addr)) begin
                o_bypass_hit  = 1'b1;
                o_bypass_data = entries[scan_idx].data;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `DSTB_LINES; i++) begin
                entries[i].valid <= 1'b0;
            end
            oldest <= '0;
            newest <= '0;
        end else begin
            if (i_commit_ack && entries[oldest].valid) begin // retire on same-cycle ack
                entries[oldest].valid <= 1'b0;
                oldest <= oldest + 1'b1;
            end
            if (store_wr) begin
                entries[newest].valid <= 1'b1;
                entries[newest].addr  <= i_addr;
                entries[newest].data  <= i_wdata;
                newest <= newest + 1'b1;
            end
        end
    end

endmodule

/* hdl/data_cache.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module data_cache (
    input  logic                      clk,
    input  logic                      rst,

    // load request
    input  logic                      i_load_en,
    input  mem_types_pkg::mem_addr_t  i_addr,

    // commit write port
    input  logic                      i_commit_valid,
    input  mem_types_pkg::mem_addr_t  i_commit_addr,
    input  mem_types_pkg::mem_word_t  i_commit_data,
    output logic                      o_commit_ack,

    // load answer
    output logic                      o_rd_valid,
    output mem_types_pkg::mem_word_t  o_rd_data,

    output logic                      o_busy
);
    import mem_types_pkg::*;
    import mem_ops_pkg::*;

    localparam int IDX_W = $clog2(`CACHE_LINES);
    localparam int TAG_W = `ADDR_WIDTH - IDX_W;
    localparam int CNT_W = $clog2(`MISS_CYCLES + 1);

    cache_state_t               state;
    logic [CNT_W-1:0]           fill_cnt;
    mem_addr_t                  fill_addr;

    logic [`CACHE_LINES-1:0]    line_valid;
    logic [TAG_W-1:0]           line_tag  [`CACHE_LINES];
    mem_word_t                  line_data [`CACHE_LINES];
    mem_word_t                  backing   [`MEM_WORDS];

    logic [IDX_W-1:0]           ld_idx;
    logic [IDX_W-1:0]           cm_idx;
    logic [IDX_W-1:0]           fill_idx;
    logic [TAG_W-1:0]           ld_tag;
    logic [TAG_W-1:0]           cm_tag;
    logic [TAG_W-1:0]           fill_tag;
    logic                       ld_start;
    logic                       ld_hit;
    logic                       cm_present;
    logic                       fill_done;

    assign ld_idx   = i_addr[IDX_W-1:0];
    assign ld_tag   = i_addr[`ADDR_WIDTH-1:IDX_W];
    assign cm_idx   = i_commit_addr[IDX_W-1:0];
    assign cm_tag   = i_commit_addr[`ADDR_WIDTH-1:IDX_W];
    assign fill_idx = fill_addr[IDX_W-1:0];
    assign fill_tag = fill_addr[`ADDR_WIDTH-1:IDX_W];

    assign ld_start   = i_load_en && (state == C_IDLE);
    assign ld_hit     = line_valid[ld_idx] && (line_tag[ld_idx] == ld_tag);
    assign cm_present = line_valid[cm_idx] && (line_tag[cm_idx] == cm_tag);
    assign fill_done  = (state == C_FILL) && (fill_cnt == '0);

    // loads win, commits only go through on a quiet idle cycle
    assign o_commit_ack = i_commit_valid && (state == C_IDLE) && !i_load_en;

    // rd_valid covers the answer cycle of a hit
    assign o_busy = (state != C_IDLE) || o_rd_valid;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= C_IDLE;
            fill_cnt   <= '0;
            o_rd_valid <= 1'b0;
            line_valid <= '0;
        end else begin
            o_rd_valid <= 1'b0;
            case (state)
                C_IDLE: begin
                    if (i_load_en) begin
                        if (ld_hit) begin
                            o_rd_valid <= 1'b1;
                        end else begin
                            state    <= C_FILL;
                            fill_cnt <= CNT_W'(`MISS_CYCLES - 1);
                        end
                    end
                end
                C_FILL: begin
                    if (fill_cnt == '0) begin
                        state                <= C_RESP;
                        o_rd_valid           <= 1'b1;
                        line_valid[fill_idx] <= 1'b1;
                    end else begin
                        fill_cnt <= fill_cnt - 1'b1;
                    end
                end
                C_RESP: state <= C_IDLE; // answer is on the port this cycle
                default: state <= C_IDLE;
            endcase
        end
    end

    // tags, line data and read data
    always_ff @(posedge clk) begin
        if (ld_start) begin
            fill_addr <= i_addr;
            o_rd_data <= line_data[ld_idx]; // only meaningful on a hit
        end
        if (fill_done) begin
            line_tag[fill_idx]  <= fill_tag;
            line_data[fill_idx] <= backing[fill_addr];
            o_rd_data           <= backing[fill_addr];
        end
        if (o_commit_ack && cm_present) begin
            line_data[cm_idx] <= i_commit_data; // no allocate on a miss
        end
    end

    // write through
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `MEM_WORDS; i++) begin
                backing[i] <= '0;
            end
        end else if (o_commit_ack) begin
            backing[i_commit_addr] <= i_commit_data;
        end
    end

endmodule

/* hdl/load_merge.sv */
`timescale 1ns/1ps

module load_merge (
    input  logic                      clk,
    input  logic                      rst,

    input  logic                      i_load_en,

    // from store buffer, sampled at issue
    input  logic                      i_bypass_hit,
    input  mem_types_pkg::mem_word_t  i_bypass_data,

    // from cache
    input  logic                      i_rd_valid,
    input  mem_types_pkg::mem_word_t  i_rd_data,

    output logic                      o_pending,
    output logic                      o_load_valid,
    output mem_types_pkg::mem_word_t  o_load_data
);
    import mem_types_pkg::*;

    logic       byp_hit_q;
    mem_word_t  byp_data_q;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            o_pending <= 1'b0;
            byp_hit_q <= 1'b0;
        end else if (i_load_en) begin
            o_pending <= 1'b1;
            byp_hit_q <= i_bypass_hit;
        end else if (i_rd_valid) begin
            o_pending <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (i_load_en) begin
            byp_data_q <= i_bypass_data;
        end
    end

    // same cycle as the cache answer
    assign o_load_valid = i_rd_valid && o_pending;

    // a pending store is newer than anything the cache holds
    assign o_load_data = byp_hit_q ? byp_data_q : i_rd_data;

endmodule

/* hdl/dmem_unit.sv */
`timescale 1ns/1ps

module dmem_unit (
    input  logic                      clk,
    input  logic                      rst,

    input  mem_ops_pkg::mem_op_t      i_op,
    input  mem_types_pkg::mem_addr_t  i_addr,
    input  mem_types_pkg::mem_word_t  i_wdata,

    output logic                      o_stall,
    output logic                      o_load_valid,
    output mem_types_pkg::mem_word_t  o_load_data,
    output logic                      o_idle
);
    import mem_types_pkg::*;
    import mem_ops_pkg::*;

    logic       store_req;
    logic       load_en;
    logic       sb_full;
    logic       sb_empty;
    logic       load_pending;

    logic       commit_valid;
    logic       commit_ack;
    mem_addr_t  commit_addr;
    mem_word_t  commit_data;

    logic       bypass_hit;
    mem_word_t  bypass_data;

    logic       rd_valid;
    mem_word_t  rd_data;
    logic       cache_busy;

    // full only depends on a store request, so no loop through stall
    assign store_req = (i_op == OP_STORE) && !load_pending;
    assign load_en   = (i_op == OP_LOAD) && !o_stall;

    assign o_stall = sb_full || load_pending;
    assign o_idle  = sb_empty && !cache_busy && !load_pending;

    store_buffer u_store_buffer (
        .clk            (clk),
        .rst            (rst),
        .i_store_en     (store_req),
        .i_addr         (i_addr),
        .i_wdata        (i_wdata),
        .i_commit_ack   (commit_ack),
        .o_commit_valid (commit_valid),
        .o_commit_addr  (commit_addr),
        .o_commit_data  (commit_data),
        .o_full         (sb_full),
        .o_empty        (sb_empty),
        .o_bypass_hit   (bypass_hit),
        .o_bypass_data  (bypass_data)
    );

    data_cache u_data_cache (
        .clk            (clk),
        .rst            (rst),
        .i_load_en      (load_en),
        .i_addr         (i_addr),
        .i_commit_valid (commit_valid),
        .i_commit_addr  (commit_addr),
        .i_commit_data  (commit_data),
        .o_commit_ack   (commit_ack),
        .o_rd_valid     (rd_valid),
        .o_rd_data      (rd_data),
        .o_busy         (cache_busy)
    );

    load_merge u_load_merge (
        .clk            (clk),
        .rst            (rst),
        .i_load_en      (load_en),
        .i_bypass_hit   (bypass_hit),
        .i_bypass_data  (bypass_data),
        .i_rd_valid     (rd_valid),
        .i_rd_data      (rd_data),
        .o_pending      (load_pending),
        .o_load_valid   (o_load_valid),
        .o_load_data    (o_load_data)
    );

endmodule

/* testbench/dmem_unit_checker.sv */
`timescale 1ns/1ps

module dmem_unit_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  mem_ops_pkg::mem_op_t  i_op,
    input  logic                  i_stall,
    input  logic                  i_load_valid,
    input  logic                  i_idle
);
    import mem_ops_pkg::*;

    logic load_out;  // accepted and not yet answered
    int   fail_count = 0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            load_out <= 1'b0;
        end else if (i_op == OP_LOAD && !i_stall) begin
            load_out <= 1'b1;
        end else if (i_load_valid) begin
            load_out <= 1'b0;
        end
    end

    valid_after_load: assert property (@(posedge clk) disable iff (rst)
        i_load_valid |-> load_out)
        else begin
            fail_count++;
            $error("load data returned without an accepted load");
        end

    no_stall_when_idle: assert property (@(posedge clk) disable iff (rst)
        (i_idle && i_op == OP_NOP) |-> !i_stall)
        else begin
            fail_count++;
            $error("stall raised while idle with no operation");
        end

    no_idle_with_load: assert property (@(posedge clk) disable iff (rst)
        load_out |-> !i_idle)
        else begin
            fail_count++;
            $error("idle reported while a load is outstanding");
        end

endmodule

bind dmem_unit dmem_unit_checker u_dmem_checker (
    .clk          (clk),
    .rst          (rst),
    .i_op         (i_op),
    .i_stall      (o_stall),
    .i_load_valid (o_load_valid),
    .i_idle       (o_idle)
);

/* testbench/dmem_unit_tb.sv */
`timescale 1ns/1ps
`include "dmem_params.svh"

module dmem_unit_tb;
    import mem_types_pkg::*;
    import mem_ops_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int MAX_OPS    = 64;
    localparam int COLS       = 4;  // op addr data gap

    // opcodes of the test data file
    localparam logic [3:0] T_NOP       = 4'h0;
    localparam logic [3:0] T_LOAD      = 4'h1;
    localparam logic [3:0] T_STORE     = 4'h2;
    localparam logic [3:0] T_WAIT_IDLE = 4'h3;
    localparam logic [3:0] T_STALL_CLR = 4'h4;
    localparam logic [3:0] T_STALL_CHK = 4'h5;
    localparam logic [3:0] T_END       = 4'hf;

    logic       clk = 1'b0;
    logic       rst;
    mem_op_t    cmd_op;
    mem_addr_t  cmd_addr;
    mem_word_t  cmd_wdata;
    logic       stall;
    logic       load_valid;
    mem_word_t  load_data;
    logic       idle;

    logic [31:0] tdata [MAX_OPS*COLS];
    mem_word_t   ref_mem [`MEM_WORDS];  // updated in program order
    logic        written [`MEM_WORDS];

    int   err_count  = 0;
    int   n_tests    = 0;
    int   n_failed   = 0;
    int   cycles     = 0;
    int   limit      = 0;
    logic stall_seen = 1'b0;

    dmem_unit dut_i (
        .clk          (clk),
        .rst          (rst),
        .i_op         (cmd_op),
        .i_addr       (cmd_addr),
        .i_wdata      (cmd_wdata),
        .o_stall      (stall),
        .o_load_valid (load_valid),
        .o_load_data  (load_data),
        .o_idle       (idle)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Something failed");
            $finish;
        end
    end

    task automatic check_load(input mem_word_t got, input mem_word_t exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s read %08h, expected %08h", $time, what, got, exp);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            err_count++;
            $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic finish_test(input string name, input int errs_before);
        n_tests++;
        if (err_count != errs_before) begin
            n_failed++;
            $display("test %0d %s: failed", n_tests, name);
        end else begin
            $display("test %0d %s: ok", n_tests, name);
        end
    endtask

    // entered on a falling edge and returns on the falling edge after acceptance
    task automatic present_op(input mem_op_t op, input mem_addr_t addr, input mem_word_t data);
        cmd_op    = op;
        cmd_addr  = addr;
        cmd_wdata = data;
        #1;
        while (stall) begin
            stall_seen = 1'b1;
            @(negedge clk);
            #1;
        end
        @(negedge clk);
        cmd_op = OP_NOP;
    endtask

    task automatic run_load(input mem_addr_t addr, input mem_word_t exp);
        int errs;
        errs = err_count;
        present_op(OP_LOAD, addr, '0);
        while (!load_valid) begin
            @(negedge clk);
        end
        check_load(load_data, exp, "load vs test data");
        check_load(load_data, ref_mem[addr], "load vs model");
        finish_test($sformatf("load %02h", addr), errs);
    endtask

    task automatic wait_for_idle();
        int errs;
        errs = err_count;
        while (!idle) begin
            @(negedge clk);
        end
        check_flag(stall, 1'b0, "stall while idle");
        finish_test("drain to idle", errs);
    endtask

    initial begin
        int          n_ops;
        int          n_stores;
        int          errs;
        logic [3:0]  op;
        mem_addr_t   addr;
        mem_word_t   data;
        logic        gap;

        void'($urandom(32'h80d7a44a));
        rst       = 1'b1;
        cmd_op    = OP_NOP;
        cmd_addr  = '0;
        cmd_wdata = '0;
        for (int a = 0; a < `MEM_WORDS; a++) begin
            ref_mem[a] = '0;
            written[a] = 1'b0;
        end

        $readmemh("testbench/dmem_testdata.txt", tdata);
        n_ops    = 0;
        n_stores = 0;
        while (n_ops < MAX_OPS && tdata[n_ops*COLS][3:0] != T_END) begin
            if (tdata[n_ops*COLS][3:0] == T_STORE) begin
                n_stores++;
            end
            n_ops++;
        end
        // final sweep adds at most one load per store
        limit = (n_ops + n_stores + 1) * (`MISS_CYCLES + `DSTB_LINES + 8);

        repeat (2) @(negedge clk);
        rst  = 1'b0;
        errs = err_count;
        check_flag(idle, 1'b1, "idle after reset");
        check_flag(load_valid, 1'b0, "load valid after reset");
        check_flag(stall, 1'b0, "stall after reset");
        finish_test("reset state", errs);

        for (int i = 0; i < n_ops; i++) begin
            op   = tdata[i*COLS][3:0];
            addr = tdata[i*COLS+1][`ADDR_WIDTH-1:0];
            data = tdata[i*COLS+2];
            gap  = tdata[i*COLS+3][0];
            case (op)
                T_NOP: @(negedge clk);
                T_LOAD: run_load(addr, data);
                T_STORE: begin
                    present_op(OP_STORE, addr, data);
                    ref_mem[addr] = data;
                    written[addr] = 1'b1;
                end
                T_WAIT_IDLE: wait_for_idle();
                T_STALL_CLR: stall_seen = 1'b0;
                T_STALL_CHK: begin
                    errs = err_count;
                    check_flag(stall_seen, data[0], "stall seen in burst");
                    finish_test("store burst stall", errs);
                end
                default: begin
                    err_count++;
                    $display("unknown opcode %0h on test data entry %0d", op, i);
                end
            endcase
            if (gap) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
            end
        end

        // every written word once more after the drain
        wait_for_idle();
        for (int a = 0; a < `MEM_WORDS; a++) begin
            if (written[a]) begin
                run_load(mem_addr_t'(a), ref_mem[a]);
            end
        end
        wait_for_idle();

        $display("tests run %0d, passed %0d, failed %0d", n_tests, n_tests - n_failed, n_failed);
        if (n_failed == 0 && err_count == 0 && dut_i.u_dmem_checker.fail_count == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* testbench/dmem_testdata.txt */
// op addr data gap, all hex; op 0 idle cycle, 1 load (data = expected), 2 store,
// 3 wait for idle, 4 clear stall mark, 5 check stall mark (data = expected), f end
1 00 00000000 1
1 a7 00000000 1
2 10 1234abcd 0
1 10 1234abcd 1
2 21 aaaa0001 0
2 21 bbbb0002 0
1 21 bbbb0002 1
2 45 cafe0045 1
3 00 00000000 0
1 45 cafe0045 0  // miss
1 45 cafe0045 1  // hit
1 4d 00000000 0  // same line, other tag
1 45 cafe0045 1
2 45 0000beef 1
3 00 00000000 0
1 45 0000beef 1
3 00 00000000 0
4 00 00000000 0
2 60 60606060 0
2 61 61616161 0
2 62 62626262 0
2 63 63636363 0
2 64 64646464 0
2 60 60600000 0
1 62 62626262 0
2 65 65656565 0
5 00 00000001 1
3 00 00000000 0
1 60 60600000 1
1 61 61616161 1
1 63 63636363 1
1 64 64646464 1
1 65 65656565 1
2 80 80808080 1
2 88 88888888 1
1 80 80808080 1
1 88 88888888 1
2 ff ffff00ff 0
1 ff ffff00ff 1
f 00 00000000 0

/* dmem_unit.f */
+incdir+hdl
hdl/mem_types_pkg.sv
hdl/mem_ops_pkg.sv
hdl/store_buffer.sv
hdl/data_cache.sv
hdl/load_merge.sv
hdl/dmem_unit.sv
testbench/dmem_unit_checker.sv
testbench/dmem_unit_tb.sv

/* run_sim.sh */
#!/bin/sh
# Verilator build and run of the dmem_unit testbench

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=dmem_unit_sim

verilator --binary --timing --assert \
    -f dmem_unit.f \
    --top-module dmem_unit_tb \
    -o "$BIN"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "Something failed" "$LOG"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "Everything OK" "$LOG"; then
    echo "FAIL: no result line in $LOG"
    exit 1
fi
echo "PASS"
exit 0
